//--- Controller.f
+incdir+verif
rtl/mipsIsaPkg.sv
rtl/mipsCtrlPkg.sv
rtl/specialDecoder.sv
rtl/opcodeDecoder.sv
rtl/controlEncoder.sv
rtl/Controller.sv
verif/controllerTb.sv

//--- rtl/Controller.sv
`timescale 1ns/100ps

module Controller (
    input  logic                  clk,
    input  logic                  reset,
    input  mipsIsaPkg::instr_t    instruction,
    output logic                  aluSrc,
    output logic                  regDst,
    output logic                  regWrite,
    output mipsCtrlPkg::aluOp_t   aluOp,
    output logic                  memRead,
    output logic                  memWrite,
    output logic                  memToReg,
    output logic                  aluSft,
    output logic                  zeroSrc,
    output logic                  branch,
    output logic                  jalSrc,
    output logic                  jZeroSrc,
    output mipsCtrlPkg::semCtrl_t semCtrl,
    output logic                  jrSrc
);
    import mipsIsaPkg::*;

    mipsOp_t specialOp;
    mipsOp_t opcodeOp;

    // both decoders see the same word
    specialDecoder uSpecial (
        .instruction (instruction),
        .specialOp   (specialOp)
    );

    opcodeDecoder uOpcode (
        .instruction (instruction),
        .opcodeOp    (opcodeOp)
    );

    controlEncoder uEncoder (
        .clk      (clk),
        .reset    (reset),
        .specialOp(specialOp),
        .opcodeOp (opcodeOp),
        .aluSrc   (aluSrc),
        .regDst   (regDst),
        .regWrite (regWrite),
        .aluOp    (aluOp),
        .memRead  (memRead),
        .memWrite (memWrite),
        .memToReg (memToReg),
        .aluSft   (aluSft),
        .zeroSrc  (zeroSrc),
        .branch   (branch),
        .jalSrc   (jalSrc),
        .jZeroSrc (jZeroSrc),
        .semCtrl  (semCtrl),
        .jrSrc    (jrSrc)
    );

endmodule

//--- rtl/controlEncoder.sv
`timescale 1ns/100ps

module controlEncoder (
    input  logic                 clk,
    input  logic                 reset,
    input  mipsIsaPkg::mipsOp_t  specialOp,
    input  mipsIsaPkg::mipsOp_t  opcodeOp,
    output logic                 aluSrc,
    output logic                 regDst,
    output logic                 regWrite,
    output mipsCtrlPkg::aluOp_t  aluOp,
    output logic                 memRead,
    output logic                 memWrite,
    output logic                 memToReg,
    output logic                 aluSft,
    output logic                 zeroSrc,
    output logic                 branch,
    output logic                 jalSrc,
    output logic                 jZeroSrc,
    output mipsCtrlPkg::semCtrl_t semCtrl,
    output logic                 jrSrc
);
    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    mipsOp_t selOp;

    // decoders never both claim a word
    assign selOp = (specialOp != OP_NONE) ? specialOp : opcodeOp;

    function automatic aluOp_t aluCode(input mipsOp_t op);
        case (op)
            OP_SUB:                      return ALU_SUB;
            OP_MUL:                      return ALU_MUL;
            OP_LUI:                      return ALU_LUI;
            OP_ADDU, OP_ADDIU:           return ALU_ADDU;
            OP_AND, OP_ANDI:             return ALU_AND;
            OP_OR, OP_ORI:               return ALU_OR;
            OP_XOR, OP_XORI:             return ALU_XOR;
            OP_NOR:                      return ALU_NOR;
            OP_SLT, OP_SLTI:             return ALU_SLT;
            OP_SLTU, OP_SLTIU:           return ALU_SLTU;
            OP_SLL, OP_SLLV:             return ALU_SLL;
            OP_SRL, OP_SRLV:             return ALU_SRL;
            OP_ROTR, OP_ROTRV:           return ALU_ROTR;
            OP_SRA, OP_SRAV:             return ALU_SRA;
            OP_MOVN:                     return ALU_MOVN;
            OP_MOVZ:                     return ALU_MOVZ;
            OP_SEH:                      return ALU_SEH;
            OP_SEB:                      return ALU_SEB;
            OP_BEQ:                      return ALU_BEQ;
            OP_BNE:                      return ALU_BNE;
            OP_BGTZ:                     return ALU_BGTZ;
            OP_BLEZ:                     return ALU_BLEZ;
            OP_BGEZ:                     return ALU_BGEZ;
            OP_BLTZ:                     return ALU_BLTZ;
            OP_J:                        return ALU_J;
            OP_JAL:                      return ALU_JAL;
            OP_JR:                       return ALU_JR;
            // add, addi, loads, stores, nop
            default:                     return ALU_ADD;
        endcase
    endfunction

    function automatic semCtrl_t semCode(input mipsOp_t op);
        case (op)
            OP_LH, OP_SH: return SEM_HALF;
            OP_LB, OP_SB: return SEM_BYTE;
            default:      return SEM_WORD;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // decode stage register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            aluOp    <= ALU_ADD;
            semCtrl  <= SEM_WORD;
            aluSrc   <= 1'b0;
            regDst   <= 1'b0;
            regWrite <= 1'b0;
            memRead  <= 1'b0;
            memWrite <= 1'b0;
            memToReg <= 1'b0;
            aluSft   <= 1'b0;
            zeroSrc  <= 1'b0;
            branch   <= 1'b0;
            jalSrc   <= 1'b0;
            jZeroSrc <= 1'b0;
            jrSrc    <= 1'b0;
        end else begin
            aluOp    <= aluCode(selOp);
            semCtrl  <= semCode(selOp);
            // group defaults, overridden below
            aluSrc   <= 1'b0;
            regDst   <= 1'b0;
            regWrite <= 1'b0;
            memRead  <= 1'b0;
            memWrite <= 1'b0;
            memToReg <= 1'b0;
            aluSft   <= 1'b0;
            zeroSrc  <= 1'b0;
            branch   <= 1'b0;
            jalSrc   <= 1'b0;
            jZeroSrc <= 1'b0;
            jrSrc    <= 1'b0;
            case (selOp)
                OP_SLL, OP_SRL, OP_ROTR, OP_SRA,
                OP_SLLV, OP_SRLV, OP_ROTRV, OP_SRAV,
                OP_ADD, OP_ADDU, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOR,
                OP_SLT, OP_SLTU, OP_MOVN, OP_MOVZ, OP_MUL, OP_SEH, OP_SEB: begin
                    regDst   <= 1'b1;
                    regWrite <= 1'b1;
                    memToReg <= 1'b1;
                    jalSrc   <= 1'b1;
                    // shamt comes from the instruction only for fixed shifts
                    aluSft   <= selOp inside {OP_SLL, OP_SRL, OP_ROTR, OP_SRA};
                end
                OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                    aluSrc   <= 1'b1;
                    regWrite <= 1'b1;
                    memToReg <= 1'b1;
                    jalSrc   <= 1'b1;
                    zeroSrc  <= selOp inside {OP_ANDI, OP_ORI, OP_XORI, OP_SLTIU};
                end
                OP_LW, OP_LH, OP_LB: begin
                    aluSrc   <= 1'b1;
                    regWrite <= 1'b1;
                    memRead  <= 1'b1;
                    jalSrc   <= 1'b1;
                end
                OP_SW, OP_SH, OP_SB: begin
                    aluSrc   <= 1'b1;
                    memWrite <= 1'b1;
                    jalSrc   <= 1'b1;
                end
                OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ, OP_BGEZ, OP_BLTZ: begin
                    branch   <= 1'b1;
                    jalSrc   <= 1'b1;
                    jZeroSrc <= 1'b1;
                end
                OP_J: begin
                    branch   <= 1'b1;
                    jalSrc   <= 1'b1;
                end
                OP_JR: begin
                    branch   <= 1'b1;
                    jalSrc   <= 1'b1;
                    jrSrc    <= 1'b1;
                end
                // link write, jalSrc low selects the return address
                OP_JAL: begin
                    branch   <= 1'b1;
                    regWrite <= 1'b1;
                    memToReg <= 1'b1;
                end
                OP_NOP: jalSrc <= 1'b1;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////
    assert property (@(posedge clk) disable iff (reset) !(memRead && memWrite));

    // a register jump still has to redirect fetch
    assert property (@(posedge clk) disable iff (reset) jrSrc |-> branch);

    assert property (@(posedge clk) reset |=>
        ({aluOp, semCtrl, aluSrc, regDst, regWrite, memRead, memWrite, memToReg,
          aluSft, zeroSrc, branch, jalSrc, jZeroSrc, jrSrc} == '0));

endmodule

//--- rtl/mipsCtrlPkg.sv
package mipsCtrlPkg;

    typedef logic [5:0] aluOp_t;
    typedef logic [1:0] semCtrl_t;

    ////////////////////////////////////////////////////////////////////////////
    // ALU operation codes
    ////////////////////////////////////////////////////////////////////////////
    // arithmetic
    localparam aluOp_t ALU_ADD  = 6'b000000;
    localparam aluOp_t ALU_SUB  = 6'b000001;
    localparam aluOp_t ALU_MUL  = 6'b000010;
    localparam aluOp_t ALU_LUI  = 6'b000110;
    localparam aluOp_t ALU_ADDU = 6'b100000;

    // branch compares and jumps
    localparam aluOp_t ALU_BGEZ = 6'b000111;
    localparam aluOp_t ALU_BEQ  = 6'b001000;
    localparam aluOp_t ALU_BNE  = 6'b001001;
    localparam aluOp_t ALU_BGTZ = 6'b001010;
    localparam aluOp_t ALU_BLEZ = 6'b001011;
    localparam aluOp_t ALU_BLTZ = 6'b001100;
    localparam aluOp_t ALU_J    = 6'b001101;
    localparam aluOp_t ALU_JAL  = 6'b001110;
    localparam aluOp_t ALU_JR   = 6'b100011;

    // logic
    localparam aluOp_t ALU_AND  = 6'b001111;
    localparam aluOp_t ALU_OR   = 6'b010000;
    localparam aluOp_t ALU_NOR  = 6'b010001;
    localparam aluOp_t ALU_XOR  = 6'b010010;

    // shifts, rotates, sign extension
    localparam aluOp_t ALU_SEH  = 6'b010011;
    localparam aluOp_t ALU_SLL  = 6'b010100;
    localparam aluOp_t ALU_SRL  = 6'b010101;
    localparam aluOp_t ALU_ROTR = 6'b011000;
    localparam aluOp_t ALU_SRA  = 6'b011001;
    localparam aluOp_t ALU_SEB  = 6'b011010;

    // conditional moves and compares
    localparam aluOp_t ALU_MOVN = 6'b010110;
    localparam aluOp_t ALU_MOVZ = 6'b010111;
    localparam aluOp_t ALU_SLT  = 6'b011011;
    localparam aluOp_t ALU_SLTU = 6'b100010;

    ////////////////////////////////////////////////////////////////////////////
    // memory access size
    ////////////////////////////////////////////////////////////////////////////
    localparam semCtrl_t SEM_WORD = 2'b00;
    localparam semCtrl_t SEM_HALF = 2'b01;
    localparam semCtrl_t SEM_BYTE = 2'b10;

endpackage

//--- rtl/mipsIsaPkg.sv
package mipsIsaPkg;

    typedef logic [31:0] instr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  regField_t;

    ////////////////////////////////////////////////////////////////////////////
    // major opcodes, instruction[31:26]
    ////////////////////////////////////////////////////////////////////////////
    localparam opcode_t OPC_SPECIAL  = 6'b000000;
    localparam opcode_t OPC_REGIMM   = 6'b000001;
    localparam opcode_t OPC_J        = 6'b000010;
    localparam opcode_t OPC_JAL      = 6'b000011;
    localparam opcode_t OPC_BEQ      = 6'b000100;
    localparam opcode_t OPC_BNE      = 6'b000101;
    localparam opcode_t OPC_BLEZ     = 6'b000110;
    localparam opcode_t OPC_BGTZ     = 6'b000111;
    localparam opcode_t OPC_ADDI     = 6'b001000;
    localparam opcode_t OPC_ADDIU    = 6'b001001;
    localparam opcode_t OPC_SLTI     = 6'b001010;
    localparam opcode_t OPC_SLTIU    = 6'b001011;
    localparam opcode_t OPC_ANDI     = 6'b001100;
    localparam opcode_t OPC_ORI      = 6'b001101;
    localparam opcode_t OPC_XORI     = 6'b001110;
    localparam opcode_t OPC_LUI      = 6'b001111;
    localparam opcode_t OPC_SPECIAL2 = 6'b011100;
    localparam opcode_t OPC_SPECIAL3 = 6'b011111;
    localparam opcode_t OPC_LB       = 6'b100000;
    localparam opcode_t OPC_LH       = 6'b100001;
    localparam opcode_t OPC_LW       = 6'b100011;
    localparam opcode_t OPC_SB       = 6'b101000;
    localparam opcode_t OPC_SH       = 6'b101001;
    localparam opcode_t OPC_SW       = 6'b101011;

    ////////////////////////////////////////////////////////////////////////////
    // function field, instruction[5:0]
    ////////////////////////////////////////////////////////////////////////////
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_JR   = 6'b001000;
    localparam funct_t FN_MOVZ = 6'b001010;
    localparam funct_t FN_MOVN = 6'b001011;
    localparam funct_t FN_ADD  = 6'b100000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUB  = 6'b100010;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;
    // SPECIAL2 only
    localparam funct_t FN_MUL  = 6'b000010;

    // REGIMM rt field
    localparam regField_t RT_BLTZ = 5'b00000;
    localparam regField_t RT_BGEZ = 5'b00001;

    // select bits inside otherwise shared encodings
    localparam int ROT_BIT  = 21;
    localparam int ROTV_BIT = 6;
    localparam int SEH_BIT  = 9;

    // OP_NONE when a decoder does not own the word
    typedef enum logic [5:0] {
        OP_NONE, OP_NOP,
        OP_SLL, OP_SRL, OP_ROTR, OP_SRA, OP_SLLV, OP_SRLV, OP_ROTRV, OP_SRAV,
        OP_JR, OP_MOVZ, OP_MOVN, OP_ADD, OP_ADDU, OP_SUB,
        OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT, OP_SLTU,
        OP_MUL, OP_SEH, OP_SEB,
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
        OP_LB, OP_LH, OP_LW, OP_SB, OP_SH, OP_SW,
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BGEZ, OP_BLTZ,
        OP_J, OP_JAL
    } mipsOp_t;

endpackage

//--- rtl/opcodeDecoder.sv
`timescale 1ns/100ps

module opcodeDecoder (
    input  mipsIsaPkg::instr_t  instruction,
    output mipsIsaPkg::mipsOp_t opcodeOp
);
    import mipsIsaPkg::*;

    opcode_t   opcode;
    regField_t rt;

    assign opcode = instruction[31:26];
    assign rt     = instruction[20:16];

    always_comb begin
        opcodeOp = OP_NONE;
        case (opcode)
            // immediate ALU
            OPC_ADDI:  opcodeOp = OP_ADDI;
            OPC_ADDIU: opcodeOp = OP_ADDIU;
            OPC_SLTI:  opcodeOp = OP_SLTI;
            OPC_SLTIU: opcodeOp = OP_SLTIU;
            OPC_ANDI:  opcodeOp = OP_ANDI;
            OPC_ORI:   opcodeOp = OP_ORI;
            OPC_XORI:  opcodeOp = OP_XORI;
            OPC_LUI:   opcodeOp = OP_LUI;

            // loads and stores
            OPC_LB:    opcodeOp = OP_LB;
            OPC_LH:    opcodeOp = OP_LH;
            OPC_LW:    opcodeOp = OP_LW;
            OPC_SB:    opcodeOp = OP_SB;
            OPC_SH:    opcodeOp = OP_SH;
            OPC_SW:    opcodeOp = OP_SW;

            // branches and jumps
            OPC_BEQ:   opcodeOp = OP_BEQ;
            OPC_BNE:   opcodeOp = OP_BNE;
            OPC_BLEZ:  opcodeOp = OP_BLEZ;
            OPC_BGTZ:  opcodeOp = OP_BGTZ;
            OPC_J:     opcodeOp = OP_J;
            OPC_JAL:   opcodeOp = OP_JAL;

            // rt picks the compare, other rt values stay unclaimed
            OPC_REGIMM: begin
                case (rt)
                    RT_BGEZ: opcodeOp = OP_BGEZ;
                    RT_BLTZ: opcodeOp = OP_BLTZ;
                    default: opcodeOp = OP_NONE;
                endcase
            end

            // SPECIAL groups belong to specialDecoder
            OPC_SPECIAL, OPC_SPECIAL2, OPC_SPECIAL3: opcodeOp = OP_NONE;
            default: opcodeOp = OP_NONE;
        endcase
    end

endmodule

//--- rtl/specialDecoder.sv
`timescale 1ns/100ps

module specialDecoder (
    input  mipsIsaPkg::instr_t  instruction,
    output mipsIsaPkg::mipsOp_t specialOp
);
    import mipsIsaPkg::*;

    opcode_t opcode;
    funct_t  funct;

    assign opcode = instruction[31:26];
    assign funct  = instruction[5:0];

    always_comb begin
        specialOp = OP_NONE;
        // all-zero word wins over sll $0,$0,0
        if (instruction == '0) begin
            specialOp = OP_NOP;
        end else begin
            case (opcode)
                OPC_SPECIAL: begin
                    case (funct)
                        FN_SLL:  specialOp = OP_SLL;
                        // rotr shares srl's function code
                        FN_SRL:  specialOp = instruction[ROT_BIT] ? OP_ROTR : OP_SRL;
                        FN_SRA:  specialOp = OP_SRA;
                        FN_SLLV: specialOp = OP_SLLV;
                        FN_SRLV: specialOp = instruction[ROTV_BIT] ? OP_ROTRV : OP_SRLV;
                        FN_SRAV: specialOp = OP_SRAV;
                        FN_JR:   specialOp = OP_JR;
                        FN_MOVZ: specialOp = OP_MOVZ;
                        FN_MOVN: specialOp = OP_MOVN;
                        FN_ADD:  specialOp = OP_ADD;
                        FN_ADDU: specialOp = OP_ADDU;
                        FN_SUB:  specialOp = OP_SUB;
                        FN_AND:  specialOp = OP_AND;
                        FN_OR:   specialOp = OP_OR;
                        FN_XOR:  specialOp = OP_XOR;
                        FN_NOR:  specialOp = OP_NOR;
                        FN_SLT:  specialOp = OP_SLT;
                        FN_SLTU: specialOp = OP_SLTU;
                        // HI/LO group falls through here
                        default: specialOp = OP_NONE;
                    endcase
                end
                OPC_SPECIAL2: begin
                    if (funct == FN_MUL) begin
                        specialOp = OP_MUL;
                    end
                end
                OPC_SPECIAL3: begin
                    specialOp = instruction[SEH_BIT] ? OP_SEH : OP_SEB;
                end
                default: specialOp = OP_NONE;
            endcase
        end
    end

endmodule

//--- runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f Controller.f --top-module controllerTb -Mdir obj_dir

./obj_dir/VcontrollerTb > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

//--- verif/controllerVectors.svh
`ifndef CONTROLLER_VECTORS_SVH
`define CONTROLLER_VECTORS_SVH

localparam int NUM_VECTORS = 51;

// columns: instruction, mask of undecoded bits, aluOp, semCtrl, then
// aluSrc regDst regWrite memRead memWrite memToReg aluSft zeroSrc branch jalSrc jZeroSrc jrSrc
localparam logic [83:0] VECTORS [NUM_VECTORS] = '{
    // register ALU group
    {32'h00021900, 32'h03FF07C0, 6'h14, 2'b00, 12'b011001100100},
    {32'h00021902, 32'h03DFFFC0, 6'h15, 2'b00, 12'b011001100100},
    {32'h00221902, 32'h03DFFFC0, 6'h18, 2'b00, 12'b011001100100},
    {32'h00021903, 32'h03FFFFC0, 6'h19, 2'b00, 12'b011001100100},
    {32'h00821804, 32'h03FFFFC0, 6'h14, 2'b00, 12'b011001000100},
    {32'h00821806, 32'h03FFFF80, 6'h15, 2'b00, 12'b011001000100},
    {32'h00821846, 32'h03FFFF80, 6'h18, 2'b00, 12'b011001000100},
    {32'h00821807, 32'h03FFFFC0, 6'h19, 2'b00, 12'b011001000100},
    // jr
    {32'h03E00008, 32'h03FFFFC0, 6'h23, 2'b00, 12'b000000001101},
    {32'h0082180A, 32'h03FFFFC0, 6'h17, 2'b00, 12'b011001000100},
    {32'h0082180B, 32'h03FFFFC0, 6'h16, 2'b00, 12'b011001000100},
    {32'h00821820, 32'h03FFFFC0, 6'h00, 2'b00, 12'b011001000100},
    {32'h00821821, 32'h03FFFFC0, 6'h20, 2'b00, 12'b011001000100},
    {32'h00821822, 32'h03FFFFC0, 6'h01, 2'b00, 12'b011001000100},
    {32'h00821824, 32'h03FFFFC0, 6'h0F, 2'b00, 12'b011001000100},
    {32'h00821825, 32'h03FFFFC0, 6'h10, 2'b00, 12'b011001000100},
    {32'h00821826, 32'h03FFFFC0, 6'h12, 2'b00, 12'b011001000100},
    {32'h00821827, 32'h03FFFFC0, 6'h11, 2'b00, 12'b011001000100},
    {32'h0082182A, 32'h03FFFFC0, 6'h1B, 2'b00, 12'b011001000100},
    {32'h0082182B, 32'h03FFFFC0, 6'h22, 2'b00, 12'b011001000100},
    // mul, seh, seb
    {32'h70821802, 32'h03FFFFC0, 6'h02, 2'b00, 12'b011001000100},
    {32'h7C021E20, 32'h03FFFDC0, 6'h13, 2'b00, 12'b011001000100},
    {32'h7C021C20, 32'h03FFFDC0, 6'h1A, 2'b00, 12'b011001000100},
    // immediates and lui
    {32'h20821234, 32'h03FFFFFF, 6'h00, 2'b00, 12'b101001000100},
    {32'h24821234, 32'h03FFFFFF, 6'h20, 2'b00, 12'b101001000100},
    {32'h28821234, 32'h03FFFFFF, 6'h1B, 2'b00, 12'b101001000100},
    {32'h2C821234, 32'h03FFFFFF, 6'h22, 2'b00, 12'b101001010100},
    {32'h30821234, 32'h03FFFFFF, 6'h0F, 2'b00, 12'b101001010100},
    {32'h34821234, 32'h03FFFFFF, 6'h10, 2'b00, 12'b101001010100},
    {32'h38821234, 32'h03FFFFFF, 6'h12, 2'b00, 12'b101001010100},
    {32'h3C021234, 32'h03FFFFFF, 6'h06, 2'b00, 12'b101001000100},
    // loads and stores
    {32'h80821234, 32'h03FFFFFF, 6'h00, 2'b10, 12'b101100000100},
    {32'h84821234, 32'h03FFFFFF, 6'h00, 2'b01, 12'b101100000100},
    {32'h8C821234, 32'h03FFFFFF, 6'h00, 2'b00, 12'b101100000100},
    {32'hA0821234, 32'h03FFFFFF, 6'h00, 2'b10, 12'b100010000100},
    {32'hA4821234, 32'h03FFFFFF, 6'h00, 2'b01, 12'b100010000100},
    {32'hAC821234, 32'h03FFFFFF, 6'h00, 2'b00, 12'b100010000100},
    // branches, REGIMM, jumps
    {32'h10820010, 32'h03FFFFFF, 6'h08, 2'b00, 12'b000000001110},
    {32'h14820010, 32'h03FFFFFF, 6'h09, 2'b00, 12'b000000001110},
    {32'h18800010, 32'h03FFFFFF, 6'h0B, 2'b00, 12'b000000001110},
    {32'h1C800010, 32'h03FFFFFF, 6'h0A, 2'b00, 12'b000000001110},
    {32'h04810010, 32'h03E0FFFF, 6'h07, 2'b00, 12'b000000001110},
    {32'h04800010, 32'h03E0FFFF, 6'h0C, 2'b00, 12'b000000001110},
    {32'h04820010, 32'h03E0FFFF, 6'h00, 2'b00, 12'b000000000000},
    {32'h08000100, 32'h03FFFFFF, 6'h0D, 2'b00, 12'b000000001100},
    {32'h0C000100, 32'h03FFFFFF, 6'h0E, 2'b00, 12'b001001001000},
    // nop, then mult, mfhi, madd and an unused opcode
    {32'h00000000, 32'h00000000, 6'h00, 2'b00, 12'b000000000100},
    {32'h00820018, 32'h03FFFFC0, 6'h00, 2'b00, 12'b000000000000},
    {32'h00001810, 32'h03FFFFC0, 6'h00, 2'b00, 12'b000000000000},
    {32'h70820000, 32'h03FFFFC0, 6'h00, 2'b00, 12'b000000000000},
    {32'hFC000000, 32'h03FFFFFF, 6'h00, 2'b00, 12'b000000000000}
};

`endif

//--- verif/controllerTb.sv
`timescale 1ns/100ps

module controllerTb;
    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_WORDS = 64;
    // add, so reset has to hold its nonzero controls off
    localparam logic [31:0] RESET_WORD = 32'h00821820;

    `include "controllerVectors.svh"

    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_VECTORS + RANDOM_WORDS + 20;

    logic     clk;
    logic     reset;
    instr_t   instruction;
    logic     aluSrc;
    logic     regDst;
    logic     regWrite;
    aluOp_t   aluOp;
    logic     memRead;
    logic     memWrite;
    logic     memToReg;
    logic     aluSft;
    logic     zeroSrc;
    logic     branch;
    logic     jalSrc;
    logic     jZeroSrc;
    semCtrl_t semCtrl;
    logic     jrSrc;

    int          checkCount;
    int          errorCount;
    integer      seed;
    string       stepLabel;
    string       pendingLabel;
    logic [19:0] pendingExp;
    bit          pendingValid;

    Controller uut (
        .clk        (clk),
        .reset      (reset),
        .instruction(instruction),
        .aluSrc     (aluSrc),
        .regDst     (regDst),
        .regWrite   (regWrite),
        .aluOp      (aluOp),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .memToReg   (memToReg),
        .aluSft     (aluSft),
        .zeroSrc    (zeroSrc),
        .branch     (branch),
        .jalSrc     (jalSrc),
        .jZeroSrc   (jZeroSrc),
        .semCtrl    (semCtrl),
        .jrSrc      (jrSrc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////////////////////
    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s: got %0h expected %0h at %s",
                     name, actual, expected, stepLabel);
        end
    endtask

    // exp is {aluOp, semCtrl, twelve single-bit controls}
    task automatic checkControls(input logic [19:0] exp);
        checkValue("aluOp",    32'(aluOp),    32'(exp[19:14]));
        checkValue("semCtrl",  32'(semCtrl),  32'(exp[13:12]));
        checkValue("aluSrc",   32'(aluSrc),   32'(exp[11]));
        checkValue("regDst",   32'(regDst),   32'(exp[10]));
        checkValue("regWrite", 32'(regWrite), 32'(exp[9]));
        checkValue("memRead",  32'(memRead),  32'(exp[8]));
        checkValue("memWrite", 32'(memWrite), 32'(exp[7]));
        checkValue("memToReg", 32'(memToReg), 32'(exp[6]));
        checkValue("aluSft",   32'(aluSft),   32'(exp[5]));
        checkValue("zeroSrc",  32'(zeroSrc),  32'(exp[4]));
        checkValue("branch",   32'(branch),   32'(exp[3]));
        checkValue("jalSrc",   32'(jalSrc),   32'(exp[2]));
        checkValue("jZeroSrc", 32'(jZeroSrc), 32'(exp[1]));
        checkValue("jrSrc",    32'(jrSrc),    32'(exp[0]));
    endtask

    // new word goes in, the previous word's controls must be on the outputs
    task automatic stepWord(input logic [31:0] word, input logic [19:0] exp,
                            input bit valid, input string label);
        @(posedge clk);
        #1;
        instruction = word;
        #1;
        if (pendingValid) begin
            stepLabel = pendingLabel;
            checkControls(pendingExp);
        end
        pendingExp   = exp;
        pendingValid = valid;
        pendingLabel = label;
    endtask

    function automatic logic [31:0] mixWord(input logic [31:0] base, input logic [31:0] mask,
                                            input logic [31:0] rnd);
        return (base & ~mask) | (rnd & mask);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin : mainFlow
        int          testErrors;
        int          idx;
        logic [83:0] entry;
        logic [31:0] word;

        seed         = 32'h1038;
        checkCount   = 0;
        errorCount   = 0;
        pendingValid = 1'b0;
        pendingExp   = '0;
        pendingLabel = "";
        stepLabel    = "reset";
        reset        = 1'b1;
        instruction  = RESET_WORD;

        // last pass releases reset, its check covers the cycle after
        testErrors = errorCount;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            #1;
            if (c == RESET_CYCLES - 1) begin
                reset = 1'b0;
            end
            #1;
            checkControls(20'h0);
        end
        $display("test reset finished with %0d errors", errorCount - testErrors);

        testErrors = errorCount;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            entry = VECTORS[i];
            stepWord(entry[83:52], entry[19:0], 1'b1, $sformatf("table entry %0d", i));
        end
        stepWord(32'h0, 20'h0, 1'b0, "flush");
        $display("test table finished with %0d errors", errorCount - testErrors);

        testErrors = errorCount;
        for (int k = 0; k < RANDOM_WORDS; k++) begin
            idx   = int'({$random(seed)} % NUM_VECTORS);
            entry = VECTORS[idx];
            word  = mixWord(entry[83:52], entry[51:20], $random(seed));
            stepWord(word, entry[19:0], 1'b1,
                     $sformatf("stream word %0d (entry %0d, %h)", k, idx, word));
        end
        stepWord(32'h0, 20'h0, 1'b0, "flush");
        $display("test streaming finished with %0d errors", errorCount - testErrors);

        $display("tests 3, checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
